// ==== vlog.f ====
+incdir+verilog
verilog/rs_pkg.sv
verilog/dispatch_stage.sv
verilog/tag_cam.sv
verilog/prio_select.sv
verilog/rs_table.sv
verilog/issue_latch.sv
verilog/rs_top.sv
bench/rs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module rs_tb -f vlog.f -o rs_sim
./obj_dir/rs_sim

// ==== bench/rs_tb.sv ====
// Reservation station testbench
// Random and directed dispatch with result bus wakeups, lsq stalls, a full
// table and a flush, with every issue packet checked against a scoreboard

`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_tb;

	import rs_pkg::*;

	localparam int NTAGS        = 1 << `TAG_W;
	localparam int PW           = `OP_W + `TAG_W;
	localparam int RAND_CYCLES  = 400;
	// Random phase plus a generous allowance for the directed phases and drains
	localparam int LIMIT_CYCLES = RAND_CYCLES + 600;

	logic              clock;
	logic              rst_n;
	logic              flush;
	logic              dispatch_valid;
	disp_inst_t        dispatch_inst;
	logic              cdb_valid;
	logic [`TAG_W-1:0] cdb_tag;
	logic              lsq_busy;
	logic              rs_full;
	logic              alu_issue_valid;
	alu_issue_t        alu_issue;
	logic              mem_issue_valid;
	mem_issue_t        mem_issue;

	// Scoreboard indexed by dest tag
	// Ready bits track the broadcasts seen so far
	disp_inst_t sb_inst  [NTAGS];
	logic       sb_pend  [NTAGS];
	logic       sb_timed [NTAGS];
	int         sb_cycle [NTAGS];
	int         pending   = 0;
	int         cyc       = 0;
	int         dest_next = 0;
	int         seed;
	logic       lsq_last  = 1'b0;
	logic       disp_last = 1'b0;

	rs_top rs_top_inst (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) cyc <= cyc + 1;

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and scoreboard helpers
	////////////////////////////////////////////////////////////////////////////

	// Expected issue packet zero extended to the ALU width
	function automatic logic [PW-1:0] expected_payload(disp_inst_t inst);
		if (inst.fu_class == CLASS_ALU) begin
			return {inst.opcode, inst.dest};
		end
		// Loads and stores carry only the direction bit and the dest tag
		return {{(PW-`TAG_W-1){1'b0}}, inst.opcode[0], inst.dest};
	endfunction

	task automatic abort_run(string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic [`TAG_W-1:0] next_dest();
		dest_next = dest_next % 31 + 1;
		while (sb_pend[dest_next]) begin
			dest_next = dest_next % 31 + 1;
		end
		return `TAG_W'(dest_next);
	endfunction

	// Unready instructions always wait on src1 and sometimes on src2
	function automatic disp_inst_t random_inst(fu_class_t cls, logic ready);
		disp_inst_t  inst;
		logic [31:0] r;
		r             = $random(seed);
		inst.fu_class = cls;
		inst.opcode   = r[3:0];
		inst.dest     = next_dest();
		inst.src1     = ready ? `NO_TAG : {1'b1, r[8:4]};
		inst.src2     = (ready || r[10:9] == 2'b00) ? `NO_TAG : {1'b1, r[15:11]};
		inst.src1_rdy = (inst.src1 == `NO_TAG);
		inst.src2_rdy = (inst.src2 == `NO_TAG);
		return inst;
	endfunction

	function automatic logic [`TAG_W-1:0] unready_tag();
		int start;
		int t;
		start = $random(seed) & (NTAGS - 1);
		for (int k = 0; k < NTAGS; k++) begin
			t = (start + k) % NTAGS;
			if (sb_pend[t] && !sb_inst[t].src1_rdy) begin
				return sb_inst[t].src1;
			end
			if (sb_pend[t] && !sb_inst[t].src2_rdy) begin
				return sb_inst[t].src2;
			end
		end
		return `NO_TAG;
	endfunction

	function automatic int pending_of_class(fu_class_t cls);
		int n;
		n = 0;
		for (int t = 0; t < NTAGS; t++) begin
			if (sb_pend[t] && sb_inst[t].fu_class == cls) begin
				n++;
			end
		end
		return n;
	endfunction

	function void mark_broadcast(logic [`TAG_W-1:0] tag);
		for (int t = 0; t < NTAGS; t++) begin
			if (sb_pend[t] && sb_inst[t].src1 == tag) begin
				sb_inst[t].src1_rdy = 1'b1;
			end
			if (sb_pend[t] && sb_inst[t].src2 == tag) begin
				sb_inst[t].src2_rdy = 1'b1;
			end
		end
	endfunction

	// One cycle of stimulus, driven at the rising edge
	task automatic drive_cycle(logic disp, disp_inst_t inst, logic bcast,
			logic [`TAG_W-1:0] tag, logic timed);
		@(posedge clock);
		dispatch_valid <= disp;
		dispatch_inst  <= inst;
		cdb_valid      <= bcast;
		cdb_tag        <= tag;
		if (disp) begin
			sb_inst[inst.dest]  = inst;
			sb_pend[inst.dest]  = 1'b1;
			sb_timed[inst.dest] = timed;
			// Edge at which these inputs were driven
			sb_cycle[inst.dest] = cyc + 1;
			pending++;
		end
		if (bcast) begin
			mark_broadcast(tag);
		end
		disp_last = disp;
	endtask

	task automatic drain_table();
		logic [`TAG_W-1:0] tag;
		do begin
			tag = unready_tag();
			drive_cycle(1'b0, '0, tag != `NO_TAG, tag, 1'b0);
			lsq_busy <= 1'b0;
		end while (pending != 0);
	endtask

	task automatic latency_check(int count);
		for (int i = 0; i < count; i++) begin
			drive_cycle(1'b1, random_inst(i[0] ? CLASS_MEM : CLASS_ALU, 1'b1), 1'b0,
				`NO_TAG, 1'b1);
			drain_table();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////////////////////

	task automatic check_issue(string sig, logic [PW-1:0] got, fu_class_t cls);
		logic [`TAG_W-1:0] d;
		d = got[`TAG_W-1:0];
		assert (sb_pend[d]) else
			abort_run($sformatf("Issued dest tag %0d on %s is not pending", d, sig));
		assert (sb_inst[d].fu_class == cls) else
			abort_run($sformatf("Dest tag %0d issued on the wrong class (%s)", d, sig));
		assert (got == expected_payload(sb_inst[d])) else
			abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, sig, got,
				expected_payload(sb_inst[d])));
		assert (sb_inst[d].src1_rdy && sb_inst[d].src2_rdy) else
			abort_run($sformatf("Dest tag %0d issued before its sources were broadcast", d));
		if (sb_timed[d]) begin
			assert (cyc - sb_cycle[d] == 3) else
				abort_run($sformatf("Fail at %0t: %s latency got %0d expected 3", $time,
					sig, cyc - sb_cycle[d]));
		end
		sb_pend[d] = 1'b0;
		pending--;
	endtask

	always @(negedge clock) begin
		if (rst_n) begin
			assert (!(mem_issue_valid && lsq_last)) else
				abort_run($sformatf("Fail at %0t: mem_issue_valid got 1 expected 0", $time));
			if (alu_issue_valid) begin
				check_issue("alu_issue", PW'(alu_issue), CLASS_ALU);
			end
			if (mem_issue_valid) begin
				check_issue("mem_issue", PW'(mem_issue), CLASS_MEM);
			end
		end
		// lsq_busy as the DUT sampled it at the last edge
		lsq_last <= lsq_busy;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0]       r;
		logic [`TAG_W-1:0] tag;
		logic              full_seen;
		int                table_cnt;
		disp_inst_t        inst;
		logic [`TAG_W-1:0] flushed [$];
		seed           = 32'h8899;
		rst_n          = 1'b0;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_inst  = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = `NO_TAG;
		lsq_busy       = 1'b0;
		for (int t = 0; t < NTAGS; t++) begin
			sb_pend[t]  = 1'b0;
			sb_timed[t] = 1'b0;
		end
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		// Ready instructions on an idle window
		latency_check(4);

		// Broadcasts in the dispatch cycle and in the staging cycle
		inst = random_inst(CLASS_ALU, 1'b0);
		drive_cycle(1'b1, inst, 1'b1, inst.src1, 1'b1);
		drive_cycle(1'b0, '0, inst.src2 != `NO_TAG, inst.src2, 1'b0);
		drain_table();

		// Random traffic with wakeups and lsq stalls
		for (int n = 0; n < RAND_CYCLES; n++) begin
			@(negedge clock);
			r   = $random(seed);
			tag = unready_tag();
			drive_cycle(r[0] && !rs_full && !disp_last,
				random_inst(r[1] ? CLASS_MEM : CLASS_ALU, r[3:2] == 2'b00),
				r[5:4] != 2'b00 && tag != `NO_TAG, tag, 1'b0);
			if (r[9:6] == 4'h0) begin
				lsq_busy <= !lsq_busy;
			end
		end
		drain_table();

		// ALU keeps issuing while the lsq holds MEM back
		drive_cycle(1'b0, '0, 1'b0, `NO_TAG, 1'b0);
		lsq_busy <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			drive_cycle(1'b1, random_inst(i[0] ? CLASS_MEM : CLASS_ALU, 1'b1), 1'b0,
				`NO_TAG, 1'b0);
			drive_cycle(1'b0, '0, 1'b0, `NO_TAG, 1'b0);
		end
		repeat (8) drive_cycle(1'b0, '0, 1'b0, `NO_TAG, 1'b0);
		@(negedge clock);
		assert (pending_of_class(CLASS_ALU) == 0) else
			abort_run($sformatf("Fail at %0t: pending ALU got %0d expected 0", $time,
				pending_of_class(CLASS_ALU)));
		assert (pending_of_class(CLASS_MEM) == 2) else
			abort_run($sformatf("Fail at %0t: pending MEM got %0d expected 2", $time,
				pending_of_class(CLASS_MEM)));
		drain_table();

		// Fill the table with waiting instructions until rs_full rises
		// One dispatch is always still on its way into the table here
		full_seen = 1'b0;
		while (!full_seen) begin
			@(negedge clock);
			full_seen = rs_full;
			table_cnt = (pending == 0) ? 0 : pending - 1;
			assert (rs_full == (table_cnt >= `RS_SIZE - 1)) else
				abort_run($sformatf("Fail at %0t: rs_full got %b expected %b", $time,
					rs_full, table_cnt >= `RS_SIZE - 1));
			drive_cycle(!rs_full && !disp_last,
				random_inst(pending[0] ? CLASS_MEM : CLASS_ALU, 1'b0), 1'b0, `NO_TAG, 1'b0);
		end
		drain_table();
		@(negedge clock);
		assert (!rs_full) else
			abort_run($sformatf("Fail at %0t: rs_full got 1 expected 0", $time));

		// Flush waiting work plus a dispatch in the flush cycle itself
		for (int i = 0; i < 3; i++) begin
			drive_cycle(1'b1, random_inst(i[0] ? CLASS_MEM : CLASS_ALU, 1'b0), 1'b0,
				`NO_TAG, 1'b0);
			drive_cycle(1'b0, '0, 1'b0, `NO_TAG, 1'b0);
		end
		for (int t = 0; t < NTAGS; t++) begin
			if (sb_pend[t]) begin
				flushed.push_back(sb_inst[t].src1);
				flushed.push_back(sb_inst[t].src2);
				sb_pend[t] = 1'b0;
			end
		end
		pending = 0;
		@(posedge clock);
		flush          <= 1'b1;
		dispatch_valid <= 1'b1;
		dispatch_inst  <= random_inst(CLASS_ALU, 1'b1);
		@(posedge clock);
		flush          <= 1'b0;
		dispatch_valid <= 1'b0;
		// Waking the flushed sources must not bring anything back
		foreach (flushed[i]) begin
			drive_cycle(1'b0, '0, flushed[i] != `NO_TAG, flushed[i], 1'b0);
		end
		repeat (6) drive_cycle(1'b0, '0, 1'b0, `NO_TAG, 1'b0);
		latency_check(2);

		if (pending == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Scoreboard still holds %0d instructions at the end", pending);
			$display("Some tests failed");
			$fatal(1, "scoreboard not empty");
		end
	end

endmodule

// ==== verilog/rs_top.sv ====
// Issue window top level
// Dispatch register, reservation table and the ALU and MEM issue registers

`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_top (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               dispatch_valid,
	input  rs_pkg::disp_inst_t dispatch_inst,
	input  logic               cdb_valid,
	input  logic [`TAG_W-1:0]  cdb_tag,
	input  logic               lsq_busy,
	output logic               rs_full,
	output logic               alu_issue_valid,
	output rs_pkg::alu_issue_t alu_issue,
	output logic               mem_issue_valid,
	output rs_pkg::mem_issue_t mem_issue
);

	import rs_pkg::*;

	logic       stage_valid;
	disp_inst_t stage_inst;
	logic       alu_grant_valid;
	rs_entry_t  alu_grant_entry;
	logic       mem_grant_valid;
	rs_entry_t  mem_grant_entry;
	alu_issue_t alu_payload;
	mem_issue_t mem_payload;

	dispatch_stage dispatch_stage_inst (
		.clock          (clock),
		.rst_n          (rst_n),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_inst  (dispatch_inst),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.stage_valid    (stage_valid),
		.stage_inst     (stage_inst)
	);

	rs_table rs_table_inst (
		.clock           (clock),
		.rst_n           (rst_n),
		.flush           (flush),
		.stage_valid     (stage_valid),
		.stage_inst      (stage_inst),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.lsq_busy        (lsq_busy),
		.rs_full         (rs_full),
		.alu_grant_valid (alu_grant_valid),
		.alu_grant_entry (alu_grant_entry),
		.mem_grant_valid (mem_grant_valid),
		.mem_grant_entry (mem_grant_entry)
	);

	// Class packet formatting
	assign alu_payload.opcode   = alu_grant_entry.inst.opcode;
	assign alu_payload.dest     = alu_grant_entry.inst.dest;
	// Opcode bit 0 selects store over load
	assign mem_payload.is_store = mem_grant_entry.inst.opcode[0];
	assign mem_payload.dest     = mem_grant_entry.inst.dest;

	issue_latch #(.payload_t(alu_issue_t)) alu_latch (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.in_valid      (alu_grant_valid),
		.in_payload    (alu_payload),
		.issue_valid   (alu_issue_valid),
		.issue_payload (alu_issue)
	);

	issue_latch #(.payload_t(mem_issue_t)) mem_latch (
		.clock         (clock),
		.rst_n         (rst_n),
		.flush         (flush),
		.in_valid      (mem_grant_valid),
		.in_payload    (mem_payload),
		.issue_valid   (mem_issue_valid),
		.issue_payload (mem_issue)
	);

endmodule

// ==== verilog/issue_latch.sv ====
// Issue output register
// Holds one class's issue packet for a single cycle strobe

`timescale 1ns/100ps

module issue_latch #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     issue_valid,
	output payload_t issue_payload
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			issue_valid <= 1'b0;
		end else begin
			// A flush kills a grant made in the same cycle
			issue_valid <= in_valid && !flush;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			issue_payload <= in_payload;
		end
	end

endmodule

// ==== verilog/rs_table.sv ====
// Reservation station table
// Holds waiting entries, merges result bus wakeups, allocates free slots
// and picks one ready entry per unit class each cycle

`timescale 1ns/100ps
`include "rs_defines.svh"

module rs_table (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               stage_valid,
	input  rs_pkg::disp_inst_t stage_inst,
	input  logic               cdb_valid,
	input  logic [`TAG_W-1:0]  cdb_tag,
	input  logic               lsq_busy,
	output logic               rs_full,
	output logic               alu_grant_valid,
	output rs_pkg::rs_entry_t  alu_grant_entry,
	output logic               mem_grant_valid,
	output rs_pkg::rs_entry_t  mem_grant_entry
);

	import rs_pkg::*;

	localparam int CNT_W = $clog2(`RS_SIZE + 1);

	logic       [`RS_SIZE-1:0] slot_busy;
	disp_inst_t [`RS_SIZE-1:0] slot_inst;
	rs_entry_t  [`RS_SIZE-1:0] entries;
	rs_entry_t  [`RS_SIZE-1:0] woken;
	logic       [`RS_SIZE-1:0] src1_hit;
	logic       [`RS_SIZE-1:0] src2_hit;
	logic       [`RS_SIZE-1:0] alloc_gnt;
	logic       [`RS_SIZE-1:0] alu_req;
	logic       [`RS_SIZE-1:0] alu_gnt;
	logic       [`RS_SIZE-1:0] mem_req;
	logic       [`RS_SIZE-1:0] mem_gnt;
	logic       [CNT_W-1:0]    busy_cnt;
	disp_inst_t                write_inst;

	////////////////////////////////////////////////////////////////////////////
	// Wakeup
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			entries[i].busy = slot_busy[i];
			entries[i].inst = slot_inst[i];
		end
	end

	tag_cam tag_cam_inst (
		.entries   (entries),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.src1_hit  (src1_hit),
		.src2_hit  (src2_hit)
	);

	// Ready bits as seen after this cycle's broadcast
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			woken[i]               = entries[i];
			woken[i].inst.src1_rdy = entries[i].inst.src1_rdy | src1_hit[i];
			woken[i].inst.src2_rdy = entries[i].inst.src2_rdy | src2_hit[i];
			alu_req[i] = woken[i].busy && woken[i].inst.src1_rdy &&
				woken[i].inst.src2_rdy && (woken[i].inst.fu_class == CLASS_ALU);
			mem_req[i] = woken[i].busy && woken[i].inst.src1_rdy &&
				woken[i].inst.src2_rdy && (woken[i].inst.fu_class == CLASS_MEM);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Selection
	////////////////////////////////////////////////////////////////////////////

	prio_select #(.N(`RS_SIZE)) alloc_sel (
		.req (~slot_busy),
		.en  (stage_valid),
		.gnt (alloc_gnt)
	);

	prio_select #(.N(`RS_SIZE)) alu_sel (
		.req (alu_req),
		.en  (1'b1),
		.gnt (alu_gnt)
	);

	// Memory issue waits while the load/store queue is busy
	prio_select #(.N(`RS_SIZE)) mem_sel (
		.req (mem_req),
		.en  (!lsq_busy),
		.gnt (mem_gnt)
	);

	assign alu_grant_valid = |alu_gnt;
	assign mem_grant_valid = |mem_gnt;

	always_comb begin
		alu_grant_entry = '0;
		mem_grant_entry = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (alu_gnt[i]) begin
				alu_grant_entry = woken[i];
			end
			if (mem_gnt[i]) begin
				mem_grant_entry = woken[i];
			end
		end
	end

	// Staged instruction also sees the broadcast on its way into a slot
	always_comb begin
		write_inst          = stage_inst;
		write_inst.src1_rdy = stage_inst.src1_rdy ||
			(cdb_valid && (stage_inst.src1 == cdb_tag));
		write_inst.src2_rdy = stage_inst.src2_rdy ||
			(cdb_valid && (stage_inst.src2 == cdb_tag));
	end

	// Full with one slot spare for the instruction held in dispatch
	always_comb begin
		busy_cnt = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			busy_cnt = busy_cnt + CNT_W'(slot_busy[i]);
		end
	end

	assign rs_full = busy_cnt >= CNT_W'(`RS_SIZE - 1);

	////////////////////////////////////////////////////////////////////////////
	// State update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			slot_busy <= '0;
		end else if (flush) begin
			slot_busy <= '0;
		end else begin
			slot_busy <= (slot_busy & ~alu_gnt & ~mem_gnt) | alloc_gnt;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (alloc_gnt[i]) begin
				slot_inst[i] <= write_inst;
			end else begin
				slot_inst[i] <= woken[i].inst;
			end
		end
	end

endmodule

// ==== verilog/prio_select.sv ====
// Fixed priority selector
// One-hot grant to the lowest-index request while enabled

`timescale 1ns/100ps

module prio_select #(
	parameter int N = 8
) (
	input  logic [N-1:0] req,
	input  logic         en,
	output logic [N-1:0] gnt
);

	always_comb begin
		logic taken;
		taken = 1'b0;
		gnt   = '0;
		if (en) begin
			for (int i = 0; i < N; i++) begin
				if (req[i] && !taken) begin
					gnt[i] = 1'b1;
					taken  = 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/tag_cam.sv ====
// Result bus tag match
// Compares the broadcast tag with both source tags of every busy entry

`timescale 1ns/100ps
`include "rs_defines.svh"

module tag_cam (
	input  rs_pkg::rs_entry_t [`RS_SIZE-1:0] entries,
	input  logic                             cdb_valid,
	input  logic [`TAG_W-1:0]                cdb_tag,
	output logic [`RS_SIZE-1:0]              src1_hit,
	output logic [`RS_SIZE-1:0]              src2_hit
);

	always_comb begin
		src1_hit = '0;
		src2_hit = '0;
		if (cdb_valid) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				// Idle slots never match
				src1_hit[i] = entries[i].busy &&
					(entries[i].inst.src1 == cdb_tag);
				src2_hit[i] = entries[i].busy &&
					(entries[i].inst.src2 == cdb_tag);
			end
		end
	end

endmodule

// ==== verilog/dispatch_stage.sv ====
// Dispatch input register
// Captures one instruction per cycle and marks operands ready
// when they have no source or are broadcast in the same cycle

`timescale 1ns/100ps
`include "rs_defines.svh"

module dispatch_stage (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               dispatch_valid,
	input  rs_pkg::disp_inst_t dispatch_inst,
	input  logic               cdb_valid,
	input  logic [`TAG_W-1:0]  cdb_tag,
	output logic               stage_valid,
	output rs_pkg::disp_inst_t stage_inst
);

	logic src1_wake;
	logic src2_wake;

	// Same-cycle wakeup so a broadcast during dispatch is not missed
	assign src1_wake = (dispatch_inst.src1 == `NO_TAG) ||
		(cdb_valid && (dispatch_inst.src1 == cdb_tag));
	assign src2_wake = (dispatch_inst.src2 == `NO_TAG) ||
		(cdb_valid && (dispatch_inst.src2 == cdb_tag));

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= dispatch_valid && !flush;
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			stage_inst          <= dispatch_inst;
			stage_inst.src1_rdy <= dispatch_inst.src1_rdy | src1_wake;
			stage_inst.src2_rdy <= dispatch_inst.src2_rdy | src2_wake;
		end
	end

endmodule

// ==== verilog/rs_pkg.sv ====
// Reservation station types
// Dispatched instruction, table entry and the per-class issue packets

`include "rs_defines.svh"

package rs_pkg;

	typedef enum logic {
		CLASS_ALU = 1'b0,
		CLASS_MEM = 1'b1
	} fu_class_t;

	// Instruction as it leaves rename
	typedef struct packed {
		fu_class_t         fu_class;
		logic [`OP_W-1:0]  opcode;
		logic [`TAG_W-1:0] dest;
		logic [`TAG_W-1:0] src1;
		logic [`TAG_W-1:0] src2;
		logic              src1_rdy;
		logic              src2_rdy;
	} disp_inst_t;

	typedef struct packed {
		logic       busy;
		disp_inst_t inst;
	} rs_entry_t;

	typedef struct packed {
		logic [`OP_W-1:0]  opcode;
		logic [`TAG_W-1:0] dest;
	} alu_issue_t;

	// Loads and stores only need the direction and the result tag
	typedef struct packed {
		logic              is_store;
		logic [`TAG_W-1:0] dest;
	} mem_issue_t;

endpackage

// ==== verilog/rs_defines.svh ====
// Reservation station sizing
// Table depth, physical tag width, opcode width and the null source tag

`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// Number of waiting entries in the issue window
`define RS_SIZE 8

// Physical register tag width
`define TAG_W 6

// Opcode field carried to the units
`define OP_W 4

// Tag zero means the operand has no source register
`define NO_TAG {`TAG_W{1'b0}}

`endif
